// ==== rtl/even_pkg.sv ====
package even_pkg;

	localparam int WORD_W = 32;		// Bits per SIMD word

	// Cycles from issue to unit result, also the slot each unit fills
	localparam int LAT_FX1 = 2;
	localparam int LAT_FX2 = 4;
	localparam int LAT_BYTE = 4;
	localparam int LAT_MUL = 6;
	localparam int WB_LAT = 8;		// Issue edge to writeback edge, inclusive

	typedef logic [6:0] reg_addr_t;	// Destination register

	typedef enum logic [1:0] {
		unit_mul = 2'd0,	// Old FP slot
		unit_fx2 = 2'd1,
		unit_byte = 2'd2,
		unit_fx1 = 2'd3
	} unit_t;

	typedef enum logic [1:0] {
		fmt_rr = 2'd0,		// Second operand is rb
		fmt_ri10 = 2'd1,	// Signed 10-bit immediate
		fmt_ri16 = 2'd2		// Signed 16-bit immediate
	} fmt_t;

	typedef enum logic [3:0] {
		op_add, op_and, op_or, op_xor,	// fx1
		op_shl, op_rot,					// fx2
		op_cntb, op_absdb, op_avgb,		// byte
		op_mpy, op_mpyu					// multiply
	} op_t;

	typedef union packed {
		struct packed { logic [7:0] unused; logic [9:0] val; } i10;		// Low 10 bits
		struct packed { logic [1:0] unused; logic [15:0] val; } i16;	// Low 16 bits
	} imm_field_t;

endpackage

// ==== rtl/exec_if.sv ====
`timescale 1ns/1ns
interface exec_if #(parameter int NUM_WORDS = 4);
	import even_pkg::*;

	logic go;								// One-cycle issue strobe
	op_t op;								// Unit-local opcode
	reg_addr_t rt_addr;						// Destination register
	logic [NUM_WORDS-1:0][WORD_W-1:0] a;	// ra value
	logic [NUM_WORDS-1:0][WORD_W-1:0] b;	// rb or replicated imm
	logic [NUM_WORDS-1:0][5:0] sh;			// Shift amount per word

	modport issue (output go, op, rt_addr, a, b, sh);
	modport unit (input go, op, rt_addr, a, b, sh);

endinterface

// ==== rtl/even_issue.sv ====
`timescale 1ns/1ns
module even_issue #(parameter int NUM_WORDS = 4) (
	input even_pkg::op_t op,
	input even_pkg::fmt_t format,
	input even_pkg::unit_t unit,
	input even_pkg::reg_addr_t rt_addr,
	input logic [NUM_WORDS-1:0][even_pkg::WORD_W-1:0] ra,
	input logic [NUM_WORDS-1:0][even_pkg::WORD_W-1:0] rb,
	input even_pkg::imm_field_t imm,
	input logic reg_write,
	exec_if.issue mul_x,
	exec_if.issue fx2_x,
	exec_if.issue byte_x,
	exec_if.issue fx1_x
);
	import even_pkg::*;

	logic [WORD_W-1:0] imm_word;				// Sign-extended immediate
	logic [NUM_WORDS-1:0][WORD_W-1:0] opnd_b;	// Second operand after format mux
	logic [NUM_WORDS-1:0][5:0] shift;			// Low 6 bits of each word of b
	logic [3:0] go_sel;							// Indexed by unit code

	always_comb begin
		case (format)
			fmt_ri10: imm_word = {{(WORD_W-10){imm.i10.val[9]}}, imm.i10.val};
			fmt_ri16: imm_word = {{(WORD_W-16){imm.i16.val[15]}}, imm.i16.val};
			default: imm_word = '0;
		endcase
		for (int w = 0; w < NUM_WORDS; w++) begin
			opnd_b[w] = (format == fmt_rr) ? rb[w] : imm_word;	// Imm goes to every word
			shift[w] = opnd_b[w][5:0];
		end
	end

	always_comb begin
		go_sel = '0;
		go_sel[unit] = reg_write;	// No reg_write, nothing issues
	end

	// Steered units see the same payload, only go differs
	assign mul_x.go = go_sel[unit_mul];
	assign mul_x.op = op;
	assign mul_x.rt_addr = rt_addr;
	assign mul_x.a = ra;
	assign mul_x.b = opnd_b;
	assign mul_x.sh = shift;

	assign fx2_x.go = go_sel[unit_fx2];
	assign fx2_x.op = op;
	assign fx2_x.rt_addr = rt_addr;
	assign fx2_x.a = ra;
	assign fx2_x.b = opnd_b;
	assign fx2_x.sh = shift;

	assign byte_x.go = go_sel[unit_byte];
	assign byte_x.op = op;
	assign byte_x.rt_addr = rt_addr;
	assign byte_x.a = ra;
	assign byte_x.b = opnd_b;
	assign byte_x.sh = shift;

	assign fx1_x.go = go_sel[unit_fx1];
	assign fx1_x.op = op;
	assign fx1_x.rt_addr = rt_addr;
	assign fx1_x.a = ra;
	assign fx1_x.b = opnd_b;
	assign fx1_x.sh = shift;

endmodule

// ==== rtl/fixed1_unit.sv ====
`timescale 1ns/1ns
module fixed1_unit #(parameter int NUM_WORDS = 4) (
	input logic clk,
	input logic reset,
	exec_if.unit x,
	output logic [NUM_WORDS-1:0][even_pkg::WORD_W-1:0] res,
	output even_pkg::reg_addr_t res_addr,
	output logic res_write
);
	import even_pkg::*;

	logic [NUM_WORDS-1:0][WORD_W-1:0] alu;						// Stage 1 logic
	logic [LAT_FX1-1:0][NUM_WORDS-1:0][WORD_W-1:0] pipe_data;	// Word results per stage
	reg_addr_t [LAT_FX1-1:0] pipe_addr;
	logic [LAT_FX1-1:0] pipe_valid;

	always_comb begin
		for (int w = 0; w < NUM_WORDS; w++) begin
			case (x.op)
				op_add: alu[w] = x.a[w] + x.b[w];	// Wraps mod 2^32
				op_and: alu[w] = x.a[w] & x.b[w];
				op_or: alu[w] = x.a[w] | x.b[w];
				op_xor: alu[w] = x.a[w] ^ x.b[w];
				default: alu[w] = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			pipe_valid <= '0;
		else
			pipe_valid <= {pipe_valid[LAT_FX1-2:0], x.go};
	end

	always_ff @(posedge clk) begin
		pipe_data <= {pipe_data[LAT_FX1-2:0], alu};		// Stage 2 is a plain re-register
		pipe_addr <= {pipe_addr[LAT_FX1-2:0], x.rt_addr};
	end

	assign res = pipe_data[LAT_FX1-1];
	assign res_addr = pipe_addr[LAT_FX1-1];
	assign res_write = pipe_valid[LAT_FX1-1];

endmodule

// ==== rtl/fixed2_unit.sv ====
`timescale 1ns/1ns
module fixed2_unit #(parameter int NUM_WORDS = 4) (
	input logic clk,
	input logic reset,
	exec_if.unit x,
	output logic [NUM_WORDS-1:0][even_pkg::WORD_W-1:0] res,
	output even_pkg::reg_addr_t res_addr,
	output logic res_write
);
	import even_pkg::*;

	logic [NUM_WORDS-1:0][WORD_W-1:0] shifted;					// Shifter output
	logic [LAT_FX2-1:0][NUM_WORDS-1:0][WORD_W-1:0] pipe_data;
	reg_addr_t [LAT_FX2-1:0] pipe_addr;
	logic [LAT_FX2-1:0] pipe_valid;

	always_comb begin
		logic [4:0] amt;
		for (int w = 0; w < NUM_WORDS; w++) begin
			amt = x.sh[w][4:0];		// Rotate uses mod 32
			if (x.op == op_rot)
				shifted[w] = (x.a[w] << amt) | (x.a[w] >> (WORD_W - amt));
			else if (x.sh[w][5])
				shifted[w] = '0;	// Shift of 32 or more clears the word
			else
				shifted[w] = x.a[w] << amt;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			pipe_valid <= '0;
		else
			pipe_valid <= {pipe_valid[LAT_FX2-2:0], x.go};
	end

	// Delay line to line up with the byte unit
	always_ff @(posedge clk) begin
		pipe_data <= {pipe_data[LAT_FX2-2:0], shifted};
		pipe_addr <= {pipe_addr[LAT_FX2-2:0], x.rt_addr};
	end

	assign res = pipe_data[LAT_FX2-1];
	assign res_addr = pipe_addr[LAT_FX2-1];
	assign res_write = pipe_valid[LAT_FX2-1];

endmodule

// ==== rtl/byte_unit.sv ====
`timescale 1ns/1ns
module byte_unit #(parameter int NUM_WORDS = 4) (
	input logic clk,
	input logic reset,
	exec_if.unit x,
	output logic [NUM_WORDS-1:0][even_pkg::WORD_W-1:0] res,
	output even_pkg::reg_addr_t res_addr,
	output logic res_write
);
	import even_pkg::*;

	logic [NUM_WORDS-1:0][WORD_W-1:0] lanes;					// All byte lanes, stage 1
	logic [LAT_BYTE-1:0][NUM_WORDS-1:0][WORD_W-1:0] pipe_data;
	reg_addr_t [LAT_BYTE-1:0] pipe_addr;
	logic [LAT_BYTE-1:0] pipe_valid;

	function automatic logic [7:0] byte_op(op_t code, logic [7:0] a, logic [7:0] b);
		logic [8:0] sum;
		sum = {1'b0, a} + {1'b0, b} + 9'd1;		// Carry kept in bit 8
		case (code)
			op_cntb: byte_op = 8'($countones(a));
			op_absdb: byte_op = (a > b) ? a - b : b - a;
			op_avgb: byte_op = sum[8:1];
			default: byte_op = '0;
		endcase
	endfunction

	always_comb begin
		for (int w = 0; w < NUM_WORDS; w++)
			for (int i = 0; i < WORD_W/8; i++)
				lanes[w][8*i +: 8] = byte_op(x.op, x.a[w][8*i +: 8], x.b[w][8*i +: 8]);
	end

	always_ff @(posedge clk) begin
		if (reset)
			pipe_valid <= '0;
		else
			pipe_valid <= {pipe_valid[LAT_BYTE-2:0], x.go};
	end

	always_ff @(posedge clk) begin
		pipe_data <= {pipe_data[LAT_BYTE-2:0], lanes};
		pipe_addr <= {pipe_addr[LAT_BYTE-2:0], x.rt_addr};
	end

	assign res = pipe_data[LAT_BYTE-1];
	assign res_addr = pipe_addr[LAT_BYTE-1];
	assign res_write = pipe_valid[LAT_BYTE-1];

endmodule

// ==== rtl/multiply_unit.sv ====
`timescale 1ns/1ns
module multiply_unit #(parameter int NUM_WORDS = 4) (
	input logic clk,
	input logic reset,
	exec_if.unit x,
	output logic [NUM_WORDS-1:0][even_pkg::WORD_W-1:0] res,
	output even_pkg::reg_addr_t res_addr,
	output logic res_write
);
	import even_pkg::*;

	logic signed_op;									// mpy extends sign, mpyu zero
	logic [NUM_WORDS-1:0][WORD_W-1:0] op_a, op_b;		// Stage 1, extended halfwords
	reg_addr_t op_addr;
	logic op_valid;
	logic [NUM_WORDS-1:0][WORD_W-1:0] prod;				// Low 32 bits are exact
	logic [LAT_MUL-2:0][NUM_WORDS-1:0][WORD_W-1:0] pipe_data;
	reg_addr_t [LAT_MUL-2:0] pipe_addr;
	logic [LAT_MUL-2:0] pipe_valid;

	assign signed_op = (x.op == op_mpy);

	always_ff @(posedge clk) begin
		for (int w = 0; w < NUM_WORDS; w++) begin
			op_a[w] <= {{(WORD_W-16){signed_op & x.a[w][15]}}, x.a[w][15:0]};
			op_b[w] <= {{(WORD_W-16){signed_op & x.b[w][15]}}, x.b[w][15:0]};
		end
		op_addr <= x.rt_addr;
		pipe_data <= {pipe_data[LAT_MUL-3:0], prod};	// Stages 2 to 6
		pipe_addr <= {pipe_addr[LAT_MUL-3:0], op_addr};
	end

	always_comb begin
		for (int w = 0; w < NUM_WORDS; w++)
			prod[w] = op_a[w] * op_b[w];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			op_valid <= 1'b0;
			pipe_valid <= '0;
		end else begin
			op_valid <= x.go;
			pipe_valid <= {pipe_valid[LAT_MUL-3:0], op_valid};
		end
	end

	assign res = pipe_data[LAT_MUL-2];
	assign res_addr = pipe_addr[LAT_MUL-2];
	assign res_write = pipe_valid[LAT_MUL-2];

	// Decode must only steer multiply codes here
	assert property (@(posedge clk) disable iff (reset) x.go |-> x.op inside {op_mpy, op_mpyu});

endmodule

// ==== rtl/result_stage.sv ====
`timescale 1ns/1ns
module result_stage #(parameter int NUM_WORDS = 4) (
	input logic clk,
	input logic reset,
	input logic [NUM_WORDS-1:0][even_pkg::WORD_W-1:0] fx1_res,
	input even_pkg::reg_addr_t fx1_addr,
	input logic fx1_write,
	input logic [NUM_WORDS-1:0][even_pkg::WORD_W-1:0] fx2_res,
	input even_pkg::reg_addr_t fx2_addr,
	input logic fx2_write,
	input logic [NUM_WORDS-1:0][even_pkg::WORD_W-1:0] byte_res,
	input even_pkg::reg_addr_t byte_addr,
	input logic byte_write,
	input logic [NUM_WORDS-1:0][even_pkg::WORD_W-1:0] mul_res,
	input even_pkg::reg_addr_t mul_addr,
	input logic mul_write,
	output logic [NUM_WORDS-1:0][even_pkg::WORD_W-1:0] rt_wb,
	output even_pkg::reg_addr_t rt_addr_wb,
	output logic reg_write_wb,
	output logic [even_pkg::WB_LAT-2:0][NUM_WORDS-1:0][even_pkg::WORD_W-1:0] fw_wb,
	output even_pkg::reg_addr_t [even_pkg::WB_LAT-2:0] fw_addr_wb,
	output logic [even_pkg::WB_LAT-2:0] fw_write_wb
);
	import even_pkg::*;

	localparam int LAST = WB_LAT - 2;	// Slot feeding writeback

	always_ff @(posedge clk) begin
		if (reset) begin
			fw_wb <= '0;
			fw_addr_wb <= '0;
			fw_write_wb <= '0;
			rt_wb <= '0;
			rt_addr_wb <= '0;
			reg_write_wb <= 1'b0;
		end else begin
			fw_wb[0] <= '0;				// No unit finishes this early
			fw_addr_wb[0] <= '0;
			fw_write_wb[0] <= 1'b0;
			for (int k = 1; k <= LAST; k++) begin
				fw_wb[k] <= fw_wb[k-1];
				fw_addr_wb[k] <= fw_addr_wb[k-1];
				fw_write_wb[k] <= fw_write_wb[k-1];
			end
			// Later assignments win over the shift
			if (fx1_write) begin
				fw_wb[LAT_FX1] <= fx1_res;
				fw_addr_wb[LAT_FX1] <= fx1_addr;
				fw_write_wb[LAT_FX1] <= 1'b1;
			end
			if (fx2_write) begin
				fw_wb[LAT_FX2] <= fx2_res;
				fw_addr_wb[LAT_FX2] <= fx2_addr;
				fw_write_wb[LAT_FX2] <= 1'b1;
			end else if (byte_write) begin
				fw_wb[LAT_BYTE] <= byte_res;
				fw_addr_wb[LAT_BYTE] <= byte_addr;
				fw_write_wb[LAT_BYTE] <= 1'b1;
			end
			if (mul_write) begin
				fw_wb[LAT_MUL] <= mul_res;
				fw_addr_wb[LAT_MUL] <= mul_addr;
				fw_write_wb[LAT_MUL] <= 1'b1;
			end
			rt_wb <= fw_wb[LAST];		// Leaves the pipe
			rt_addr_wb <= fw_addr_wb[LAST];
			reg_write_wb <= fw_write_wb[LAST];
		end
	end

	// Same latency, so single issue keeps these apart
	assert property (@(posedge clk) disable iff (reset) !(fx2_write && byte_write));

endmodule

// ==== rtl/even_pipe.sv ====
`timescale 1ns/1ns
module even_pipe #(parameter int NUM_WORDS = 4) (
	input logic clk,
	input logic reset,
	input even_pkg::op_t op,
	input even_pkg::fmt_t format,
	input even_pkg::unit_t unit,
	input even_pkg::reg_addr_t rt_addr,
	input logic [NUM_WORDS-1:0][even_pkg::WORD_W-1:0] ra,
	input logic [NUM_WORDS-1:0][even_pkg::WORD_W-1:0] rb,
	input even_pkg::imm_field_t imm,
	input logic reg_write,
	output logic [NUM_WORDS-1:0][even_pkg::WORD_W-1:0] rt_wb,
	output even_pkg::reg_addr_t rt_addr_wb,
	output logic reg_write_wb,
	output logic [even_pkg::WB_LAT-2:0][NUM_WORDS-1:0][even_pkg::WORD_W-1:0] fw_wb,
	output even_pkg::reg_addr_t [even_pkg::WB_LAT-2:0] fw_addr_wb,
	output logic [even_pkg::WB_LAT-2:0] fw_write_wb
);
	import even_pkg::*;

	exec_if #(.NUM_WORDS(NUM_WORDS)) mul_x(), fx2_x(), byte_x(), fx1_x();	// Decode to units

	logic [NUM_WORDS-1:0][WORD_W-1:0] fx1_res, fx2_res, byte_res, mul_res;
	reg_addr_t fx1_addr, fx2_addr, byte_addr, mul_addr;
	logic fx1_write, fx2_write, byte_write, mul_write;

	even_issue #(.NUM_WORDS(NUM_WORDS)) u_issue (
		.op, .format, .unit, .rt_addr, .ra, .rb, .imm, .reg_write,
		.mul_x, .fx2_x, .byte_x, .fx1_x
	);

	fixed1_unit #(.NUM_WORDS(NUM_WORDS)) u_fx1 (.clk, .reset, .x(fx1_x),
		.res(fx1_res), .res_addr(fx1_addr), .res_write(fx1_write));

	fixed2_unit #(.NUM_WORDS(NUM_WORDS)) u_fx2 (.clk, .reset, .x(fx2_x),
		.res(fx2_res), .res_addr(fx2_addr), .res_write(fx2_write));

	byte_unit #(.NUM_WORDS(NUM_WORDS)) u_byte (.clk, .reset, .x(byte_x),
		.res(byte_res), .res_addr(byte_addr), .res_write(byte_write));

	multiply_unit #(.NUM_WORDS(NUM_WORDS)) u_mul (.clk, .reset, .x(mul_x),
		.res(mul_res), .res_addr(mul_addr), .res_write(mul_write));

	// Unit results merge into the forwarding chain here
	result_stage #(.NUM_WORDS(NUM_WORDS)) u_result (.*);

endmodule

// ==== bench/even_pipe_tb.sv ====
`timescale 1ns/1ns
module even_pipe_tb;
	import even_pkg::*;

	localparam int NUM_WORDS = 4;
	localparam int VEC_W = NUM_WORDS * WORD_W;	// Flat register width
	localparam int NUM_ISSUE = 300;
	localparam int HIST_LEN = 1024;
	localparam int DRAIN_LIMIT = 20;			// Edges allowed for the pipe to empty

	logic clk = 1'b0;
	logic reset;
	op_t op;
	fmt_t format;
	unit_t unit;
	reg_addr_t rt_addr;
	logic [NUM_WORDS-1:0][WORD_W-1:0] ra, rb;
	imm_field_t imm;
	logic reg_write;
	logic [NUM_WORDS-1:0][WORD_W-1:0] rt_wb;
	reg_addr_t rt_addr_wb;
	logic reg_write_wb;
	logic [WB_LAT-2:0][NUM_WORDS-1:0][WORD_W-1:0] fw_wb;
	reg_addr_t [WB_LAT-2:0] fw_addr_wb;
	logic [WB_LAT-2:0] fw_write_wb;

	integer seed = 32'h2bbb_9af9;
	int edge_cnt = 0;				// Posedges seen so far
	int errors = 0;
	int issue_count = 0;
	int wb_count = 0;
	int drain_cycles;

	// Model history, indexed by the edge that sampled the instruction
	logic hist_valid [HIST_LEN];
	logic [VEC_W-1:0] hist_data [HIST_LEN];
	reg_addr_t hist_addr [HIST_LEN];
	int hist_lat [HIST_LEN];

	even_pipe #(.NUM_WORDS(NUM_WORDS)) UUT (.*);

	always #50 clk = ~clk;

	always @(posedge clk)
		edge_cnt <= edge_cnt + 1;

	function automatic logic [31:0] next_random();
		next_random = $random(seed);
	endfunction

	function automatic logic [WORD_W-1:0] fx1_word(op_t o, logic [WORD_W-1:0] a,
			logic [WORD_W-1:0] b);
		case (o)
			op_add: fx1_word = a + b;
			op_and: fx1_word = a & b;
			op_or: fx1_word = a | b;
			default: fx1_word = a ^ b;
		endcase
	endfunction

	function automatic logic [WORD_W-1:0] fx2_word(op_t o, logic [WORD_W-1:0] a, logic [5:0] s);
		logic [2*WORD_W-1:0] dbl;
		dbl = {a, a} << s[4:0];				// Upper half is the rotation
		if (o == op_rot)
			fx2_word = dbl[2*WORD_W-1:WORD_W];
		else if (s >= 6'd32)
			fx2_word = '0;
		else
			fx2_word = a << s;
	endfunction

	function automatic logic [WORD_W-1:0] byte_word(op_t o, logic [WORD_W-1:0] a,
			logic [WORD_W-1:0] b);
		logic [7:0] ab, bb;
		logic [7:0] ones;
		for (int i = 0; i < WORD_W/8; i++) begin
			ab = a[8*i +: 8];
			bb = b[8*i +: 8];
			ones = '0;
			for (int j = 0; j < 8; j++)
				ones = ones + 8'(ab[j]);
			case (o)
				op_cntb: byte_word[8*i +: 8] = ones;
				op_absdb: byte_word[8*i +: 8] = (ab >= bb) ? ab - bb : bb - ab;
				default: byte_word[8*i +: 8] = 8'((int'(ab) + int'(bb) + 1) / 2);	// Rounded average
			endcase
		end
	endfunction

	function automatic logic [WORD_W-1:0] mul_word(op_t o, logic [WORD_W-1:0] a,
			logic [WORD_W-1:0] b);
		logic signed [WORD_W-1:0] sp;
		logic [WORD_W-1:0] up;
		sp = $signed(a[15:0]) * $signed(b[15:0]);
		up = a[15:0] * b[15:0];
		mul_word = (o == op_mpy) ? sp : up;
	endfunction

	function automatic logic [VEC_W-1:0] expected_result(unit_t u, op_t o, fmt_t f,
			logic [VEC_W-1:0] ra_v, logic [VEC_W-1:0] rb_v, logic [17:0] imm_v);
		logic [WORD_W-1:0] imm_word, a_word, b_word;
		case (f)
			fmt_ri10: imm_word = {{(WORD_W-10){imm_v[9]}}, imm_v[9:0]};
			fmt_ri16: imm_word = {{(WORD_W-16){imm_v[15]}}, imm_v[15:0]};
			default: imm_word = '0;
		endcase
		for (int w = 0; w < NUM_WORDS; w++) begin
			a_word = ra_v[w*WORD_W +: WORD_W];
			b_word = (f == fmt_rr) ? rb_v[w*WORD_W +: WORD_W] : imm_word;	// Imm in every word
			case (u)
				unit_fx1: expected_result[w*WORD_W +: WORD_W] = fx1_word(o, a_word, b_word);
				unit_fx2: expected_result[w*WORD_W +: WORD_W] = fx2_word(o, a_word, b_word[5:0]);
				unit_byte: expected_result[w*WORD_W +: WORD_W] = byte_word(o, a_word, b_word);
				default: expected_result[w*WORD_W +: WORD_W] = mul_word(o, a_word, b_word);
			endcase
		end
	endfunction

	task automatic check_value(input string name, input logic [VEC_W-1:0] exp,
			input logic [VEC_W-1:0] got);
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	// Compares every slot and writeback against the history after the last edge
	task automatic check_outputs();
		int e;
		int src;
		logic hit;
		logic [VEC_W-1:0] exp_data;
		reg_addr_t exp_addr;
		e = edge_cnt;
		for (int k = 0; k <= WB_LAT-1; k++) begin
			src = e - k;
			hit = 1'b0;
			exp_data = '0;
			exp_addr = '0;
			if (k >= 2 && src >= 0) begin
				hit = hist_valid[src] && (hist_lat[src] <= k);	// Unit done by slot k
				if (hit) begin
					exp_data = hist_data[src];
					exp_addr = hist_addr[src];
				end
			end
			if (k < WB_LAT-1) begin
				check_value($sformatf("fw_wb[%0d]", k), exp_data, fw_wb[k]);
				check_value($sformatf("fw_addr_wb[%0d]", k), VEC_W'(exp_addr),
					VEC_W'(fw_addr_wb[k]));
				check_value($sformatf("fw_write_wb[%0d]", k), VEC_W'(hit),
					VEC_W'(fw_write_wb[k]));
			end else begin
				check_value("rt_wb", exp_data, rt_wb);
				check_value("rt_addr_wb", VEC_W'(exp_addr), VEC_W'(rt_addr_wb));
				check_value("reg_write_wb", VEC_W'(hit), VEC_W'(reg_write_wb));
			end
		end
		if (reg_write_wb)
			wb_count++;
	endtask

	task automatic drive_instr(input int i);
		logic [31:0] r;
		unit_t u;
		int idx;
		r = next_random();
		if (i < 16) begin
			case (i % 4)		// mul then fx1, fx2 then byte
				0: u = unit_mul;
				1: u = unit_fx1;
				2: u = unit_fx2;
				default: u = unit_byte;
			endcase
			reg_write = 1'b1;
		end else begin
			u = unit_t'(r[1:0]);
			reg_write = (r[4:2] != 3'd0);	// Roughly one in eight dropped
		end
		unit = u;
		r = next_random();
		case (u)
			unit_fx1: op = op_t'(4'(int'(op_add) + r % 4));
			unit_fx2: op = op_t'(4'(int'(op_shl) + r % 2));
			unit_byte: op = op_t'(4'(int'(op_cntb) + r % 3));
			default: op = op_t'(4'(int'(op_mpy) + r % 2));
		endcase
		r = next_random();
		format = fmt_t'(2'(r % 3));
		rt_addr = r[14:8];
		r = next_random();
		imm = r[17:0];
		for (int w = 0; w < NUM_WORDS; w++) begin
			ra[w] = next_random();
			rb[w] = next_random();
		end
		idx = edge_cnt + 1;		// Edge that samples these inputs
		hist_valid[idx] = reg_write;
		hist_data[idx] = expected_result(u, op, format, ra, rb, imm);
		hist_addr[idx] = rt_addr;
		case (u)
			unit_fx1: hist_lat[idx] = LAT_FX1;
			unit_fx2: hist_lat[idx] = LAT_FX2;
			unit_byte: hist_lat[idx] = LAT_BYTE;
			default: hist_lat[idx] = LAT_MUL;
		endcase
		if (reg_write)
			issue_count++;
	endtask

	initial begin
		reset = 1'b1;
		reg_write = 1'b0;
		op = op_add;
		format = fmt_rr;
		unit = unit_fx1;
		rt_addr = '0;
		ra = '0;
		rb = '0;
		imm = '0;
		for (int i = 0; i < HIST_LEN; i++) begin
			hist_valid[i] = 1'b0;
			hist_data[i] = '0;
			hist_addr[i] = '0;
			hist_lat[i] = 0;
		end
		repeat (3) @(negedge clk);
		reset = 1'b0;
		check_value("reg_write_wb", '0, VEC_W'(reg_write_wb));	// Quiet after reset
		check_value("fw_write_wb", '0, VEC_W'(fw_write_wb));
		for (int i = 0; i < NUM_ISSUE; i++) begin
			drive_instr(i);
			@(negedge clk);
			check_outputs();
		end
		reg_write = 1'b0;
		drain_cycles = 0;
		while (wb_count < issue_count && drain_cycles < DRAIN_LIMIT) begin
			@(negedge clk);
			check_outputs();
			drain_cycles++;
		end
		assert (wb_count == issue_count) else begin
			errors++;
			$display("Pipe did not drain in time, %0d of %0d results written back",
				wb_count, issue_count);
		end
		$display("Summary: %0d errors, %0d issued, %0d written back",
			errors, issue_count, wb_count);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== all.f ====
rtl/even_pkg.sv
rtl/exec_if.sv
rtl/even_issue.sv
rtl/fixed1_unit.sv
rtl/fixed2_unit.sv
rtl/byte_unit.sv
rtl/multiply_unit.sv
rtl/result_stage.sv
rtl/even_pipe.sv
bench/even_pipe_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the even pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module even_pipe_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status, see build.log"
	exit 1
fi

./obj_dir/Veven_pipe_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Checks failed" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi

echo "Simulation finished without failure"
exit 0
